/* compile.f */
+incdir+src
src/periph_pkg.sv
src/bus_decoder.sv
src/esp_uart_tx.sv
src/esp_uart_rx.sv
src/rx_fifo.sv
src/periph_top.sv
testbench/tb_periph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_periph -o tb_periph \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_periph > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* testbench/tb_periph.sv */
`timescale 1ns/100ps
`default_nettype none

`include "periph_config.svh"

module tb_periph
    import periph_pkg::*;
;

    localparam int CLKS           = `UART_CLKS_PER_BIT;
    localparam int DEPTH          = `RXFIFO_DEPTH;
    localparam int TIMEOUT_CYCLES = (40 * 10 * CLKS + 200 * 12) * 2;

    logic       sysclk;
    logic       reset;
    bus_req_t   bus;
    logic       cassette_in;
    logic       printer_in;
    logic       uart_rxd;
    logic       uart_cts;
    logic [7:0] d_out;
    logic       d_oe;
    logic       ram_ce_n;
    bank_regs_t banks;
    logic       cassette_out;
    logic       printer_out;
    logic       uart_txd;
    logic       uart_rts;
    logic [7:0] cpu_data;

    int         errors = 0;
    int         tests = 0;
    int         test_err_start = 0;
    int         cycles = 0;
    logic       last_oe;
    logic       cts_window;     // Transmitter must stay idle

    periph_top i_dut (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus          (bus),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .ram_ce_n     (ram_ce_n),
        .banks        (banks),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .uart_rxd     (uart_rxd),
        .uart_cts     (uart_cts),
        .uart_txd     (uart_txd),
        .uart_rts     (uart_rts)
    );

    assign cpu_data = d_oe ? d_out : 8'hFF;    // Pull-ups on the Z80 data bus

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////
    // Bus-level assertions
    ////////////////////
    a_drive_only_on_read: assert property (
        @(posedge sysclk) disable iff (reset) d_oe |-> (!bus.rd_n && !bus.iorq_n))
        else begin
            $display("[ERROR] %0t d_oe expected 0 got 1", $time);
            errors++;
        end

    a_txd_held_by_cts: assert property (
        @(posedge sysclk) disable iff (reset) cts_window |-> uart_txd)
        else begin
            $display("[ERROR] %0t uart_txd expected 1 got 0", $time);
            errors++;
        end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp)
        else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp)
        else begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s %0d errors", tests, name, errors - test_err_start);
        test_err_start = errors;
    endtask

    // Control/status port layout
    function automatic logic [7:0] status_byte(input logic ovf, input logic frm,
                                               input logic brk, input logic busy,
                                               input logic ne);
        return {3'b000, ovf, frm, brk, busy, ne};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    ////////////////////
    // Bus and line tasks
    ////////////////////
    task automatic bus_write(input logic [7:0] port, input logic [7:0] data);
        @(negedge sysclk);
        bus.addr   = {8'h00, port};
        bus.wrdata = data;
        bus.iorq_n = 1'b0;
        bus.wr_n   = 1'b0;
        repeat (6) @(negedge sysclk);
        bus.wr_n   = 1'b1;
        bus.iorq_n = 1'b1;
        repeat (3) @(negedge sysclk);
    endtask

    task automatic bus_read(input logic [7:0] port, output logic [7:0] data);
        @(negedge sysclk);
        bus.addr   = {8'h00, port};
        bus.iorq_n = 1'b0;
        bus.rd_n   = 1'b0;
        @(negedge sysclk);
        data    = cpu_data;     // Before the pop edge
        last_oe = d_oe;
        repeat (5) @(negedge sysclk);
        bus.rd_n   = 1'b1;
        bus.iorq_n = 1'b1;
        repeat (3) @(negedge sysclk);
    endtask

    task automatic mem_probe(input logic [15:0] addr, input logic mreq, input logic exp_ce_n);
        @(negedge sysclk);
        bus.addr   = addr;
        bus.mreq_n = !mreq;
        bus.rd_n   = 1'b0;
        @(negedge sysclk);
        check_bit("ram_ce_n", exp_ce_n, ram_ce_n);
        bus.rd_n   = 1'b1;
        bus.mreq_n = 1'b1;
        repeat (3) @(negedge sysclk);
    endtask

    task automatic uart_send_byte(input logic [7:0] data, input logic bad_stop);
        @(negedge sysclk);
        uart_rxd = 1'b0;                        // Start bit
        repeat (CLKS) @(negedge sysclk);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = data[i];
            repeat (CLKS) @(negedge sysclk);
        end
        uart_rxd = !bad_stop;
        repeat (CLKS) @(negedge sysclk);
        uart_rxd = 1'b1;                        // One idle bit
        repeat (CLKS) @(negedge sysclk);
    endtask

    task automatic line_break(input int bits);
        @(negedge sysclk);
        uart_rxd = 1'b0;
        repeat (bits * CLKS) @(negedge sysclk);
        uart_rxd = 1'b1;
        repeat (2 * CLKS) @(negedge sysclk);
    endtask

    // Samples txd at bit centres once a start edge shows up
    task automatic capture_tx_frame(output logic [7:0] data, output logic frame_ok);
        @(negedge sysclk);
        while (uart_txd) @(negedge sysclk);
        repeat (CLKS / 2) @(negedge sysclk);
        frame_ok = !uart_txd;
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge sysclk);
            data[i] = uart_txd;
        end
        repeat (CLKS) @(negedge sysclk);
        frame_ok = frame_ok && uart_txd;        // Stop bit
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    logic [7:0] rd;
    logic [7:0] b;
    logic [7:0] got;
    logic       ok;
    logic [7:0] bank_port;
    logic [7:0] exp_bank [4];
    logic [7:0] sent [$];

    initial begin
        void'($urandom(41));
        bus         = '{addr: 16'h0000, wrdata: 8'h00, rd_n: 1'b1, wr_n: 1'b1,
                        mreq_n: 1'b1, iorq_n: 1'b1};
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        uart_rxd    = 1'b1;
        uart_cts    = 1'b0;
        cts_window  = 1'b0;
        last_oe     = 1'b0;
        reset       = 1'b1;
        repeat (5) @(negedge sysclk);
        reset = 1'b0;

        // 1: reset state
        @(negedge sysclk);
        check_bit("d_oe", 1'b0, d_oe);
        check_bit("ram_ce_n", 1'b1, ram_ce_n);
        check_bit("uart_txd", 1'b1, uart_txd);
        check_bit("uart_rts", 1'b0, uart_rts);
        check_byte("banks.bank0", 8'h00, banks.bank0);
        check_byte("banks.bank1", 8'h00, banks.bank1);
        check_byte("banks.bank2", 8'h00, banks.bank2);
        check_byte("banks.bank3", 8'h00, banks.bank3);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", 8'h00, rd);
        finish_test("reset");

        // 2: registers, RAM select, unmapped port
        for (int i = 0; i < 4; i++) begin
            bank_port   = PORT_BANK0 + 8'(i);
            exp_bank[i] = random_byte();
            bus_write(bank_port, exp_bank[i]);
        end
        for (int i = 0; i < 4; i++) begin
            bank_port = PORT_BANK0 + 8'(i);
            bus_read(bank_port, rd);
            check_byte("bank readback", exp_bank[i], rd);
        end
        check_byte("banks.bank0", exp_bank[0], banks.bank0);
        check_byte("banks.bank1", exp_bank[1], banks.bank1);
        check_byte("banks.bank2", exp_bank[2], banks.bank2);
        check_byte("banks.bank3", exp_bank[3], banks.bank3);
        for (int i = 0; i < 2; i++) begin
            b    = random_byte();
            b[0] = 1'(i);                       // Both values of bit 0 across passes
            bus_write(PORT_CASSETTE, b);
            check_bit("cassette_out", b[0], cassette_out);
            bus_write(PORT_PRINTER, ~b);
            check_bit("printer_out", ~b[0], printer_out);
            cassette_in = b[0];
            printer_in  = ~b[0];
            bus_read(PORT_CASSETTE, rd);
            check_byte("FC input", {7'b0, b[0]}, rd);
            bus_read(PORT_PRINTER, rd);
            check_byte("FE input", {7'b0, ~b[0]}, rd);
        end
        mem_probe(16'h0000, 1'b1, 1'b1);
        mem_probe(16'h37FF, 1'b1, 1'b1);
        mem_probe(16'h3800, 1'b1, 1'b0);
        mem_probe(16'h8000, 1'b1, 1'b0);
        mem_probe(16'hBFFF, 1'b1, 1'b0);
        mem_probe(16'hC000, 1'b1, 1'b1);
        mem_probe(16'h8000, 1'b0, 1'b1);
        bus_read(8'h10, rd);
        check_bit("d_oe (port 10)", 1'b0, last_oe);
        check_byte("data bus (port 10)", 8'hFF, rd);
        finish_test("registers");

        // 3: transmit, then transmit held off by CTS
        b = random_byte();
        fork
            capture_tx_frame(got, ok);
            begin
                bus_write(PORT_ESPDATA, b);
                bus_read(PORT_ESPCTRL, rd);
                check_bit("F4 tx_busy", 1'b1, rd[1]);
            end
        join
        check_byte("uart_txd data", b, got);
        check_bit("uart_txd framing", 1'b1, ok);
        repeat (CLKS) @(negedge sysclk);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 0, 0, 0, 0), rd);
        uart_cts   = 1'b1;
        b          = random_byte();
        bus_write(PORT_ESPDATA, b);
        cts_window = 1'b1;
        repeat (3 * CLKS) @(negedge sysclk);
        bus_read(PORT_ESPCTRL, rd);
        check_bit("F4 tx_busy", 1'b1, rd[1]);
        cts_window = 1'b0;
        fork
            capture_tx_frame(got, ok);
            uart_cts = 1'b0;
        join
        check_byte("uart_txd data", b, got);
        check_bit("uart_txd framing", 1'b1, ok);
        repeat (CLKS) @(negedge sysclk);
        bus_read(PORT_ESPCTRL, rd);
        check_bit("F4 tx_busy", 1'b0, rd[1]);
        finish_test("transmit");

        // 4: receive order
        sent.delete();
        for (int i = 0; i < 4; i++) begin
            sent.push_back(random_byte());
            uart_send_byte(sent[i], 1'b0);
        end
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 0, 0, 0, 1), rd);
        for (int i = 0; i < 4; i++) begin
            bus_read(PORT_ESPDATA, rd);
            check_byte("F5 data", sent[i], rd);
        end
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 0, 0, 0, 0), rd);
        finish_test("receive");

        // 5: one byte past a full FIFO
        sent.delete();
        for (int i = 0; i <= DEPTH; i++) begin
            sent.push_back(random_byte());
            uart_send_byte(sent[i], 1'b0);
        end
        check_bit("uart_rts", 1'b1, uart_rts);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(1, 0, 0, 0, 1), rd);
        for (int i = 0; i < DEPTH; i++) begin
            bus_read(PORT_ESPDATA, rd);
            check_byte("F5 data", sent[i], rd);
        end
        check_bit("uart_rts", 1'b0, uart_rts);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(1, 0, 0, 0, 0), rd);
        bus_write(PORT_ESPCTRL, 8'h10);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 0, 0, 0, 0), rd);
        finish_test("overflow");

        // 6: framing error and line break
        uart_send_byte(8'hA5, 1'b1);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 1, 0, 0, 0), rd);
        line_break(12);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 1, 1, 0, 0), rd);
        bus_write(PORT_ESPCTRL, 8'h0C);
        bus_read(PORT_ESPCTRL, rd);
        check_byte("F4 status", status_byte(0, 0, 0, 0, 0), rd);
        finish_test("errors");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_top
    import periph_pkg::*;
(
    input  logic       sysclk,
    input  logic       reset,

    // Z80 side
    input  bus_req_t   bus,
    output logic [7:0] d_out,
    output logic       d_oe,
    output logic       ram_ce_n,
    output bank_regs_t banks,

    input  logic       cassette_in,
    input  logic       printer_in,
    output logic       cassette_out,
    output logic       printer_out,

    // Microcontroller link
    input  logic       uart_rxd,
    input  logic       uart_cts,
    output logic       uart_txd,
    output logic       uart_rts
);

    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_break;
    logic       tx_busy;
    rx_byte_t   rx_data;
    logic       rx_valid;
    logic       rx_framing;
    logic       rx_brk;
    rx_byte_t   fifo_head;
    logic       fifo_read;
    logic       fifo_not_empty;
    logic       fifo_full;
    logic       fifo_overflow;
    uart_err_t  err;

    assign err      = '{overflow: fifo_overflow, framing: rx_framing, brk: rx_brk};
    assign uart_rts = fifo_full;       // Ask the sender to pause

    bus_decoder i_decoder (
        .sysclk         (sysclk),
        .reset          (reset),
        .bus            (bus),
        .cassette_in    (cassette_in),
        .printer_in     (printer_in),
        .tx_busy        (tx_busy),
        .fifo_head      (fifo_head),
        .fifo_not_empty (fifo_not_empty),
        .err            (err),
        .d_out          (d_out),
        .d_oe           (d_oe),
        .ram_ce_n       (ram_ce_n),
        .banks          (banks),
        .cassette_out   (cassette_out),
        .printer_out    (printer_out),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_break       (tx_break),
        .fifo_read      (fifo_read)
    );

    esp_uart_tx i_uart_tx (
        .sysclk   (sysclk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_break (tx_break),
        .uart_cts (uart_cts),
        .uart_txd (uart_txd),
        .tx_busy  (tx_busy)
    );

    esp_uart_rx i_uart_rx (
        .sysclk   (sysclk),
        .reset    (reset),
        .uart_rxd (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .framing  (rx_framing),
        .brk      (rx_brk)
    );

    rx_fifo i_rx_fifo (
        .sysclk    (sysclk),
        .reset     (reset),
        .wr_data   (rx_data),
        .wr_en     (rx_valid),
        .rd_en     (fifo_read),
        .head      (fifo_head),
        .not_empty (fifo_not_empty),
        .full      (fifo_full),
        .overflow  (fifo_overflow)
    );

endmodule

`default_nettype wire

/* src/rx_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "periph_config.svh"

module rx_fifo
    import periph_pkg::*;
#(
    parameter int unsigned DEPTH = `RXFIFO_DEPTH
) (
    input  logic     sysclk,
    input  logic     reset,
    input  rx_byte_t wr_data,
    input  logic     wr_en,
    input  logic     rd_en,
    output rx_byte_t head,
    output logic     not_empty,
    output logic     full,
    output logic     overflow
);

    localparam int unsigned AW = $clog2(DEPTH);

    if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("rx_fifo DEPTH must be a power of two");
    end

    rx_byte_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full      = count == (AW + 1)'(DEPTH);
    assign not_empty = count != '0;
    assign do_wr     = wr_en && !full;
    assign do_rd     = rd_en && not_empty;      // Pop on empty ignored
    assign overflow  = wr_en && full;           // Byte dropped
    assign head      = mem[rd_ptr];

    always_ff @(posedge sysclk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge sysclk) disable iff (reset) count <= (AW + 1)'(DEPTH))
        else $error("rx_fifo count above DEPTH");

endmodule

`default_nettype wire

/* src/esp_uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "periph_config.svh"

module esp_uart_rx
    import periph_pkg::*;
(
    input  logic     sysclk,
    input  logic     reset,
    input  logic     uart_rxd,
    output rx_byte_t rx_data,
    output logic     rx_valid,
    output logic     framing,
    output logic     brk
);

    localparam int unsigned CLKS       = `UART_CLKS_PER_BIT;
    localparam int unsigned CW         = $clog2(CLKS);
    localparam int unsigned BRK_CYCLES = 10 * CLKS;
    localparam int unsigned LW         = $clog2(BRK_CYCLES + 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t        state;
    logic [2:0]    rxd_r;       // Two sync flops, then previous sample
    logic          rxd;
    logic          fall;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [LW-1:0] low_cnt;
    logic          bit_end;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset)
            rxd_r <= 3'b111;
        else
            rxd_r <= {rxd_r[1:0], uart_rxd};
    end

    assign rxd     = rxd_r[1];
    assign fall    = rxd_r[2] && !rxd_r[1];
    assign bit_end = clk_cnt == CW'(CLKS - 1);

    always_ff @(posedge sysclk) begin
        if (state == DATA && bit_end)
            rx_data <= {rxd, rx_data[7:1]};     // LSB first
    end

    ////////////////////
    // Frame FSM
    ////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            framing  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            framing  <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (fall)
                        state <= START;
                end

                START: begin
                    if (clk_cnt == CW'(CLKS / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd ? IDLE : DATA;   // Glitch if high again
                    end
                end

                DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= STOP;
                    end
                end

                default: begin
                    if (bit_end) begin
                        rx_valid <= rxd;
                        framing  <= !rxd;
                        state    <= IDLE;           // Next start needs a falling edge
                    end
                end
            endcase
        end
    end

    // Break: line low for ten bit times, reported once
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            low_cnt <= '0;
            brk     <= 1'b0;
        end else begin
            brk <= 1'b0;
            if (rxd) begin
                low_cnt <= '0;
            end else if (low_cnt != LW'(BRK_CYCLES)) begin
                low_cnt <= low_cnt + 1'b1;
                brk     <= low_cnt == LW'(BRK_CYCLES - 1);
            end
        end
    end

    a_valid_or_framing: assert property (
        @(posedge sysclk) disable iff (reset) !(rx_valid && framing))
        else $error("rx_valid and framing together");

endmodule

`default_nettype wire

/* src/esp_uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "periph_config.svh"

module esp_uart_tx (
    input  logic       sysclk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    input  logic       tx_break,
    input  logic       uart_cts,
    output logic       uart_txd,
    output logic       tx_busy
);

    localparam int unsigned CLKS = `UART_CLKS_PER_BIT;
    localparam int unsigned CW   = $clog2(CLKS);

    typedef enum logic [1:0] {IDLE, WAIT_CTS, FRAME, BREAK} state_t;

    state_t        state;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;
    logic [3:0]    last_bit;
    logic [8:0]    shift;       // Data bits then stop bit
    logic          bit_end;

    assign bit_end  = clk_cnt == CW'(CLKS - 1);
    assign last_bit = (state == BREAK) ? 4'(`BREAK_BITS - 1) : 4'd9;
    assign tx_busy  = state != IDLE;

    always_ff @(posedge sysclk) begin
        if (state == IDLE && tx_valid)
            shift <= {1'b1, tx_data};
        else if (state == FRAME && bit_end)
            shift <= {1'b1, shift[8:1]};
    end

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (tx_break) begin
                        state    <= BREAK;
                        uart_txd <= 1'b0;
                    end else if (tx_valid) begin
                        state    <= uart_cts ? WAIT_CTS : FRAME;
                        uart_txd <= uart_cts;       // Start bit unless held off
                    end
                end

                WAIT_CTS: begin
                    if (!uart_cts) begin
                        state    <= FRAME;
                        uart_txd <= 1'b0;
                    end
                end

                default: begin                      // FRAME or BREAK
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (state == FRAME)
                            uart_txd <= shift[0];
                        if (bit_cnt == last_bit) begin
                            state    <= IDLE;
                            uart_txd <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    a_idle_line_high: assert property (
        @(posedge sysclk) disable iff (reset) !tx_busy |-> uart_txd)
        else $error("txd low while transmitter idle");

endmodule

`default_nettype wire

/* src/bus_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_decoder
    import periph_pkg::*;
(
    input  logic       sysclk,
    input  logic       reset,

    input  bus_req_t   bus,
    input  logic       cassette_in,
    input  logic       printer_in,
    input  logic       tx_busy,
    input  rx_byte_t   fifo_head,
    input  logic       fifo_not_empty,
    input  uart_err_t  err,

    output logic [7:0] d_out,
    output logic       d_oe,
    output logic       ram_ce_n,
    output bank_regs_t banks,
    output logic       cassette_out,
    output logic       printer_out,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic       tx_break,
    output logic       fifo_read
);

    logic [2:0] wr_n_r;
    logic [2:0] rd_n_r;
    logic       bus_write;
    logic       bus_read;
    logic [7:0] wrdata;
    io_port_e   port;
    logic       io_sel;
    logic       internal;
    logic [2:0] status_r;       // Overflow, framing, break

    ////////////////////
    // Strobe sync
    ////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_r <= 3'b111;
            rd_n_r <= 3'b111;
        end else begin
            wr_n_r <= {wr_n_r[1:0], bus.wr_n};
            rd_n_r <= {rd_n_r[1:0], bus.rd_n};
        end
    end

    // One pulse per falling strobe, two cycles late
    assign bus_write = wr_n_r[2:1] == 2'b10;
    assign bus_read  = rd_n_r[2:1] == 2'b10;

    always_ff @(posedge sysclk) begin
        if (!bus.wr_n)
            wrdata <= bus.wrdata;       // Tracks the pins during the write
    end

    ////////////////////
    // Address decode
    ////////////////////
    assign port   = io_port_e'(bus.addr[7:0]);
    assign io_sel = !bus.iorq_n;

    // System RAM plus banks 1 and 2
    assign ram_ce_n = !(!bus.mreq_n && bus.addr >= 16'h3800 && bus.addr <= 16'hBFFF);

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks        <= '0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
            status_r     <= 3'b000;
        end else begin
            if (io_sel && bus_write) begin
                case (port)
                    PORT_BANK0:    banks.bank0  <= wrdata;
                    PORT_BANK1:    banks.bank1  <= wrdata;
                    PORT_BANK2:    banks.bank2  <= wrdata;
                    PORT_BANK3:    banks.bank3  <= wrdata;
                    PORT_ESPCTRL:  status_r     <= status_r & ~wrdata[4:2];
                    PORT_CASSETTE: cassette_out <= wrdata[0];
                    PORT_PRINTER:  printer_out  <= wrdata[0];
                    default: ;
                endcase
            end

            // A new event wins over a clear in the same cycle
            if (err.overflow) status_r[2] <= 1'b1;
            if (err.framing)  status_r[1] <= 1'b1;
            if (err.brk)      status_r[0] <= 1'b1;
        end
    end

    ////////////////////
    // UART strobes
    ////////////////////
    assign tx_data   = wrdata;
    assign tx_valid  = io_sel && bus_write && port == PORT_ESPDATA;
    assign tx_break  = io_sel && bus_write && port == PORT_ESPCTRL && wrdata[7];
    assign fifo_read = io_sel && bus_read && port == PORT_ESPDATA;   // Pop after the read

    // Read data mux
    always_comb begin
        d_out    = 8'h00;
        internal = 1'b1;
        case (port)
            PORT_BANK0:    d_out = banks.bank0;
            PORT_BANK1:    d_out = banks.bank1;
            PORT_BANK2:    d_out = banks.bank2;
            PORT_BANK3:    d_out = banks.bank3;
            PORT_ESPCTRL:  d_out = {3'b000, status_r, tx_busy, fifo_not_empty};
            PORT_ESPDATA:  d_out = fifo_head;
            PORT_CASSETTE: d_out = {7'b0, cassette_in};
            PORT_PRINTER:  d_out = {7'b0, printer_in};
            default:       internal = 1'b0;
        endcase
    end

    assign d_oe = !bus.rd_n && io_sel && internal;

    // A CPU access is either a read or a write
    a_tx_pop_exclusive: assert property (
        @(posedge sysclk) disable iff (reset) !(tx_valid && fifo_read))
        else $error("tx_valid and fifo_read in the same cycle");

endmodule

`default_nettype wire

/* src/periph_pkg.sv */
`default_nettype none

`include "periph_config.svh"

package periph_pkg;

    // One Z80 access as seen at the pins
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wrdata;
        logic        rd_n;
        logic        wr_n;
        logic        mreq_n;
        logic        iorq_n;
    } bus_req_t;

    typedef struct packed {
        logic [7:0] bank3;
        logic [7:0] bank2;
        logic [7:0] bank1;
        logic [7:0] bank0;
    } bank_regs_t;

    typedef logic [7:0] rx_byte_t;  // FIFO entry

    // Single-cycle event pulses from the receive path
    typedef struct packed {
        logic overflow;
        logic framing;
        logic brk;
    } uart_err_t;

    typedef enum logic [7:0] {
        PORT_BANK0    = `IO_BANK0,
        PORT_BANK1    = `IO_BANK1,
        PORT_BANK2    = `IO_BANK2,
        PORT_BANK3    = `IO_BANK3,
        PORT_ESPCTRL  = `IO_ESPCTRL,
        PORT_ESPDATA  = `IO_ESPDATA,
        PORT_CASSETTE = `IO_CASSETTE,
        PORT_PRINTER  = `IO_PRINTER
    } io_port_e;

endpackage

`default_nettype wire

/* src/periph_config.svh */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// I/O port addresses
`define IO_BANK0           8'hF0
`define IO_BANK1           8'hF1
`define IO_BANK2           8'hF2
`define IO_BANK3           8'hF3
`define IO_ESPCTRL         8'hF4
`define IO_ESPDATA         8'hF5
`define IO_CASSETTE        8'hFC
`define IO_PRINTER         8'hFE

// Serial link to the microcontroller
`define UART_CLKS_PER_BIT  16     // sysclk cycles per bit
`define BREAK_BITS         12     // Bit times of a transmitted break

// Receive buffer, power of two
`define RXFIFO_DEPTH       8

`endif
